/* Bender.yml */
package:
  name: mem_access_unit

sources:
  - hw/memOpPkg.sv
  - hw/busPkg.sv
  - hw/storeFormatter.sv
  - hw/loadFormatter.sv
  - hw/accessSequencer.sv
  - hw/memAccessUnit.sv
  - target: test
    files:
      - verification/memModel.sv
      - verification/tbMemAccessUnit.sv

/* files.f */
hw/memOpPkg.sv
hw/busPkg.sv
hw/storeFormatter.sv
hw/loadFormatter.sv
hw/accessSequencer.sv
hw/memAccessUnit.sv
verification/memModel.sv
verification/tbMemAccessUnit.sv

/* hw/accessSequencer.sv */
`timescale 1ns/1ps

// request acceptance, alignment check, single bus cycle and response
module accessSequencer
	import memOpPkg::*;
	import busPkg::*;
#(
	parameter int ADDR_WIDTH = 32
)
(
	input logic iCLK,
	input logic iRST,
	// requester side
	input logic iReqValid,
	output logic oReqReady,
	input accessOpT iReqOp,
	input logic [ADDR_WIDTH-1:0] iReqAddr,
	input wordT iReqData,
	output logic oRespValid,
	output wordT oRespData,
	output logic oRespError,
	// bus side
	output logic [ADDR_WIDTH-1:0] oBusAddr,
	output byteEnableT oBusByteEnable,
	output logic oBusWriteEnable,
	output logic oBusReadEnable,
	// formatters
	output accessOpT oAccessOp,
	output laneT oLane,
	output wordT oStoreData,
	input wordT iLaneData,
	input byteEnableT iLaneEnable,
	input wordT iLoadValue
);

	typedef enum logic [1:0] {stIdle, stAccess, stRespond} seqStateT;

	seqStateT state;
	accessOpT opReg; // held op of the access in flight
	logic [ADDR_WIDTH-1:0] addrReg;
	wordT storeDataReg;
	logic errReg; // misaligned request
	logic accept;
	logic inAccess;
	logic storeOp;
	wordT storeProbe; // bus data shifted back down to lane 0

	assign accept = iReqValid && oReqReady;
	assign inAccess = (state == stAccess);
	assign storeOp = isStore(opReg);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= stIdle;
			errReg <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (accept)
					begin
						errReg <= isMisaligned(iReqOp, iReqAddr[1:0]);
						// misaligned skips the bus entirely
						if (isMisaligned(iReqOp, iReqAddr[1:0]))
						begin
							state <= stRespond;
						end
						else
						begin
							state <= stAccess;
						end
					end
				end
				stAccess: state <= stRespond; // memory answers next cycle
				default: state <= stIdle; // response lasts one cycle
			endcase
		end
	end

	// payload capture, no reset needed
	always_ff @(posedge iCLK)
	begin
		if (accept)
		begin
			opReg <= iReqOp;
			addrReg <= iReqAddr;
			storeDataReg <= iReqData;
		end
	end

	assign oReqReady = (state == stIdle);

	// formatter inputs come straight from the held request
	assign oAccessOp = opReg;
	assign oLane = laneT'(addrReg[1:0]); // lane kept registered through the read
	assign oStoreData = storeDataReg;

	assign oBusAddr = {addrReg[ADDR_WIDTH-1:2], 2'b00}; // word aligned
	assign oBusWriteEnable = inAccess && storeOp;
	assign oBusReadEnable = inAccess && !storeOp;
	always_comb
	begin
		if (oBusWriteEnable)
		begin
			oBusByteEnable = iLaneEnable;
		end
		else if (oBusReadEnable)
		begin
			oBusByteEnable = '1; // reads fetch the whole word
		end
		else
		begin
			oBusByteEnable = '0;
		end
	end

	assign oRespValid = (state == stRespond);
	assign oRespError = oRespValid && errReg;
	// only a good load returns data
	assign oRespData = (oRespValid && !errReg && !storeOp) ? iLoadValue : '0;

	assign storeProbe = iLaneData >> {oLane, 3'b000};

	aWrRdExclusive: assert property (@(posedge iCLK) disable iff (iRST)
		!(oBusWriteEnable && oBusReadEnable));
	aWrHasLanes: assert property (@(posedge iCLK) disable iff (iRST)
		oBusWriteEnable |-> (oBusByteEnable != '0));
	// formatter must place the low store byte on the addressed lane
	aStoreLane: assert property (@(posedge iCLK) disable iff (iRST)
		oBusWriteEnable |-> (storeProbe[7:0] == storeDataReg[7:0]));
	aRespPulse: assert property (@(posedge iCLK) disable iff (iRST)
		oRespValid |=> !oRespValid);

endmodule

/* hw/busPkg.sv */
package busPkg;

	// data bus geometry
	localparam int DATA_WIDTH = 32;
	localparam int BYTE_LANES = DATA_WIDTH / 8;

	// one bus word
	typedef logic [DATA_WIDTH-1:0] wordT;

	// one enable per byte lane, bit n = lane n
	typedef logic [BYTE_LANES-1:0] byteEnableT;

	// byte offset inside a word, little-endian
	typedef logic [$clog2(BYTE_LANES)-1:0] laneT;

endpackage

/* hw/loadFormatter.sv */
`timescale 1ns/1ps

// lane selection and extension of a returned read word
module loadFormatter
	import memOpPkg::*;
	import busPkg::*;
(
	input accessOpT iAccessOp,
	input laneT iLane,
	input wordT iRawWord,
	output wordT oLoadValue
);

	logic [7:0] selByte; // byte at iLane
	logic [15:0] selHalf; // half at lane 0 or 2

	assign selByte = iRawWord[{iLane, 3'b000} +: 8];
	// lane bit 0 ignored, alignment already checked upstream
	assign selHalf = iRawWord[{iLane[1], 4'b0000} +: 16];

	always_comb
	begin
		case (iAccessOp)
			opLb:
			begin
				oLoadValue = {{(DATA_WIDTH-8){selByte[7]}}, selByte}; // sign extend
			end
			opLbu:
			begin
				oLoadValue = {{(DATA_WIDTH-8){1'b0}}, selByte};
			end
			opLh:
			begin
				oLoadValue = {{(DATA_WIDTH-16){selHalf[15]}}, selHalf}; // sign extend
			end
			opLhu:
			begin
				oLoadValue = {{(DATA_WIDTH-16){1'b0}}, selHalf};
			end
			default:
			begin
				oLoadValue = iRawWord; // lw, stores don't care
			end
		endcase
	end

	// lanes 1 and 3 only ever carry byte loads
	// halfwords come from lane 0 or lane 2

endmodule

/* hw/memAccessUnit.sv */
`timescale 1ns/1ps

// memory access path: sequencer plus store and load formatting
module memAccessUnit
	import memOpPkg::*;
	import busPkg::*;
#(
	parameter int ADDR_WIDTH = 32
)
(
	input logic iCLK,
	input logic iRST,
	input logic iReqValid,
	output logic oReqReady,
	input accessOpT iReqOp,
	input logic [ADDR_WIDTH-1:0] iReqAddr,
	input wordT iReqData,
	output logic oRespValid,
	output wordT oRespData,
	output logic oRespError,
	output logic [ADDR_WIDTH-1:0] oBusAddr,
	output wordT oBusWriteData,
	output byteEnableT oBusByteEnable,
	output logic oBusWriteEnable,
	output logic oBusReadEnable,
	input wordT iBusReadData
);

	accessOpT accessOp; // held op
	laneT lane; // held low address bits
	wordT storeData;
	byteEnableT laneEnable;
	wordT loadValue; // extended read result

	accessSequencer #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_seq (
		.iCLK(iCLK),
		.iRST(iRST),
		.iReqValid(iReqValid),
		.oReqReady(oReqReady),
		.iReqOp(iReqOp),
		.iReqAddr(iReqAddr),
		.iReqData(iReqData),
		.oRespValid(oRespValid),
		.oRespData(oRespData),
		.oRespError(oRespError),
		.oBusAddr(oBusAddr),
		.oBusByteEnable(oBusByteEnable),
		.oBusWriteEnable(oBusWriteEnable),
		.oBusReadEnable(oBusReadEnable),
		.oAccessOp(accessOp),
		.oLane(lane),
		.oStoreData(storeData),
		.iLaneData(oBusWriteData), // steered data, also checked by the sequencer
		.iLaneEnable(laneEnable),
		.iLoadValue(loadValue)
	);

	storeFormatter u_store (
		.iAccessOp(accessOp),
		.iLane(lane),
		.iStoreData(storeData),
		.oLaneData(oBusWriteData),
		.oLaneEnable(laneEnable)
	);

	// read word goes in raw, straight off the bus
	loadFormatter u_load (
		.iAccessOp(accessOp),
		.iLane(lane),
		.iRawWord(iBusReadData),
		.oLoadValue(loadValue)
	);

endmodule

/* hw/memOpPkg.sv */
package memOpPkg;

	// MIPS primary opcodes of the loads and stores handled here
	typedef enum logic [5:0]
	{
		opLb  = 6'h20,
		opLh  = 6'h21,
		opLw  = 6'h23,
		opLbu = 6'h24,
		opLhu = 6'h25,
		opSb  = 6'h28,
		opSh  = 6'h29,
		opSw  = 6'h2B
	} accessOpT;

	// stores write memory, everything else reads it
	function automatic logic isStore(accessOpT op);
		return op inside {opSb, opSh, opSw};
	endfunction

	// natural alignment: bytes never trap, halves need bit 0 clear, words need 1:0 clear
	function automatic logic isMisaligned(accessOpT op, logic [1:0] lowAddr);
		case (op)
			opLh, opLhu, opSh: return lowAddr[0];
			opLw, opSw: return |lowAddr;
			default: return 1'b0; // byte access
		endcase
	endfunction

endpackage

/* hw/storeFormatter.sv */
`timescale 1ns/1ps

// store data steering, purely combinational
module storeFormatter
	import memOpPkg::*;
	import busPkg::*;
(
	input accessOpT iAccessOp,
	input laneT iLane,
	input wordT iStoreData,
	output wordT oLaneData,
	output byteEnableT oLaneEnable
);

	always_comb
	begin
		oLaneData = iStoreData; // word store and loads see data unchanged
		oLaneEnable = '0; // loads never write
		case (iAccessOp)
			opSb:
			begin
				// same byte on every lane, only the addressed one enabled
				oLaneData = {BYTE_LANES{iStoreData[7:0]}};
				oLaneEnable = byteEnableT'(1) << iLane;
			end
			opSh:
			begin
				oLaneData = {(BYTE_LANES/2){iStoreData[15:0]}}; // low half on both halves
				if (iLane[1])
				begin
					oLaneEnable = byteEnableT'(4'b1100); // upper halfword
				end
				else
				begin
					oLaneEnable = byteEnableT'(4'b0011); // lower halfword
				end
			end
			opSw:
			begin
				oLaneEnable = '1; // full word
			end
			default:
			begin
				oLaneEnable = '0;
			end
		endcase
	end

endmodule

/* verification/memModel.sv */
`timescale 1ns/1ps

// 256-word bus memory, byte enables on writes, read data one cycle after read enable
module memModel
	import busPkg::*;
(
	input logic iCLK,
	input logic [7:0] wordAddr,
	input wordT writeData,
	input byteEnableT byteEnable,
	input logic writeEnable,
	input logic readEnable,
	output wordT readData
);

	wordT mem [256];

	initial
	begin
		for (int i = 0; i < 256; i++)
		begin
			mem[i] = '0; // starts cleared
		end
		readData = '0;
	end

	always @(posedge iCLK)
	begin
		if (writeEnable)
		begin
			for (int lane = 0; lane < BYTE_LANES; lane++)
			begin
				if (byteEnable[lane])
				begin
					mem[wordAddr][8*lane +: 8] <= writeData[8*lane +: 8]; // only enabled lanes
				end
			end
		end
		if (readEnable)
		begin
			readData <= mem[wordAddr]; // never stalls
		end
	end

endmodule

/* verification/tbMemAccessUnit.sv */
`timescale 1ns/1ps

module tbMemAccessUnit
	import memOpPkg::*;
	import busPkg::*;
();

	localparam int TIMEOUT = 20; // cycles per wait
	localparam int MEM_BYTES = 1024; // 256 words in the model

	logic iCLK;
	logic iRST;
	logic reqValid;
	logic reqReady;
	accessOpT reqOp;
	logic [31:0] reqAddr;
	wordT reqData;
	logic respValid;
	wordT respData;
	logic respError;
	logic [31:0] busAddr;
	wordT busWriteData;
	byteEnableT busByteEnable;
	logic busWriteEnable;
	logic busReadEnable;
	wordT busReadData;
	logic [7:0] refMem [MEM_BYTES]; // expected memory, byte per entry
	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;

	memAccessUnit u_dut (
		.iCLK(iCLK), .iRST(iRST),
		.iReqValid(reqValid), .oReqReady(reqReady), .iReqOp(reqOp),
		.iReqAddr(reqAddr), .iReqData(reqData),
		.oRespValid(respValid), .oRespData(respData), .oRespError(respError),
		.oBusAddr(busAddr), .oBusWriteData(busWriteData), .oBusByteEnable(busByteEnable),
		.oBusWriteEnable(busWriteEnable), .oBusReadEnable(busReadEnable),
		.iBusReadData(busReadData)
	);

	memModel u_mem (
		.iCLK(iCLK), .wordAddr(busAddr[9:2]), .writeData(busWriteData),
		.byteEnable(busByteEnable), .writeEnable(busWriteEnable),
		.readEnable(busReadEnable), .readData(busReadData)
	);

	always #5 iCLK = ~iCLK;

	// galois form, one output bit per step
	function automatic logic nextBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
		begin
			lfsrState = lfsrState ^ 32'hA300_0000;
		end
		return outBit;
	endfunction

	function automatic logic [31:0] randomBits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], nextBit()};
		end
		return value;
	endfunction

	function automatic int accessBytes(accessOpT op);
		case (op)
			opLb, opLbu, opSb: return 1;
			opLh, opLhu, opSh: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic logic writesMemory(accessOpT op);
		return (op == opSb) || (op == opSh) || (op == opSw);
	endfunction

	// little-endian gather from the byte model, then extension
	function automatic wordT expectedLoad(accessOpT op, logic [31:0] addr);
		wordT raw;
		raw = '0;
		for (int i = accessBytes(op) - 1; i >= 0; i--)
		begin
			raw = {raw[23:0], refMem[(addr + i) % MEM_BYTES]};
		end
		case (op)
			opLb: return {{24{raw[7]}}, raw[7:0]};
			opLh: return {{16{raw[15]}}, raw[15:0]};
			default: return raw; // unsigned loads and lw
		endcase
	endfunction

	task automatic checkValue(string name, wordT got, wordT expected);
		checkCount++;
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic checkTrue(logic ok, string what);
		checkCount++;
		assert (ok)
		else
		begin
			errorCount++;
			$display("%s at %0t", what, $time);
		end
	endtask

	task automatic abortRun(string reason);
		errorCount++;
		$display("timeout: %s at %0t", reason, $time);
		$display("%0d checks, %0d errors", checkCount, errorCount);
		$display("TESTS FAILED");
		$finish;
	endtask

	// drive one request, wait for acceptance and the response pulse
	task automatic issue(input accessOpT op, input logic [31:0] addr, input wordT data,
		output wordT gotData, output logic gotError, output int latency, output int busCycles);
		int waitCount;
		byteEnableT expEnable;
		wordT laneMask;
		// lanes touched by a store, reads fetch the whole word
		expEnable = '1;
		if (writesMemory(op))
		begin
			expEnable = byteEnableT'(((1 << accessBytes(op)) - 1) << addr[1:0]);
		end
		laneMask = '0;
		for (int i = 0; i < BYTE_LANES; i++)
		begin
			if (expEnable[i])
			begin
				laneMask[8*i +: 8] = 8'hFF;
			end
		end
		@(posedge iCLK);
		reqValid <= 1'b1;
		reqOp <= op;
		reqAddr <= addr;
		reqData <= data;
		waitCount = 0;
		@(negedge iCLK);
		while (!reqReady && waitCount < TIMEOUT)
		begin
			@(negedge iCLK);
			waitCount++;
		end
		if (!reqReady)
		begin
			abortRun("oReqReady never went high");
		end
		@(posedge iCLK); // acceptance edge
		reqValid <= 1'b0;
		latency = 0;
		busCycles = 0;
		do
		begin
			@(negedge iCLK);
			latency++;
			checkTrue(!reqReady, "oReqReady high while an access is in flight");
			if (busWriteEnable || busReadEnable)
			begin
				busCycles++;
				checkValue("oBusAddr", busAddr, {addr[31:2], 2'b00});
				checkValue("oBusByteEnable", busByteEnable, expEnable);
				checkValue("oBusWriteEnable", busWriteEnable, writesMemory(op));
				if (busWriteEnable)
				begin
					// store bytes sit on their little-endian lanes
					checkValue("oBusWriteData", busWriteData & laneMask,
						(data << (8 * addr[1:0])) & laneMask);
				end
			end
		end
		while (!respValid && latency < TIMEOUT);
		if (!respValid)
		begin
			abortRun("no response pulse after acceptance");
		end
		gotData = respData;
		gotError = respError;
	endtask

	// one access checked against the byte model, which is updated on good stores
	task automatic runAccess(input accessOpT op, input logic [31:0] addr, input wordT data,
		output wordT loadValue);
		wordT gotData;
		logic gotError;
		int latency;
		int busCycles;
		logic misaligned;
		wordT expected;
		misaligned = (addr % accessBytes(op)) != 0;
		expected = (misaligned || writesMemory(op)) ? '0 : expectedLoad(op, addr);
		issue(op, addr, data, gotData, gotError, latency, busCycles);
		checkValue("oRespData", gotData, expected);
		checkValue("oRespError", gotError, misaligned);
		checkTrue(latency == (misaligned ? 1 : 2), "response came at the wrong cycle");
		checkTrue(busCycles == (misaligned ? 0 : 1), "wrong number of bus enable cycles");
		if (writesMemory(op) && !misaligned)
		begin
			for (int i = 0; i < accessBytes(op); i++)
			begin
				refMem[(addr + i) % MEM_BYTES] = data[8*i +: 8];
			end
		end
		loadValue = gotData;
	endtask

	task automatic testResetAndWord();
		wordT value;
		checkTrue(reqReady === 1'b1, "oReqReady not high after reset");
		checkTrue(respValid === 1'b0 && respError === 1'b0, "response flags high after reset");
		checkTrue(!busWriteEnable && !busReadEnable && busByteEnable == '0,
			"bus enable active after reset");
		runAccess(opSw, 32'h10, 32'hDEAD_BEEF, value);
		runAccess(opLw, 32'h10, '0, value);
		checkValue("oRespData", value, 32'hDEAD_BEEF);
	endtask

	task automatic testByteLanes();
		wordT value;
		runAccess(opSb, 32'h20, 32'hAA11, value); // upper bits ignored
		runAccess(opSb, 32'h21, 32'h22, value);
		runAccess(opSb, 32'h22, 32'h33, value);
		runAccess(opSb, 32'h23, 32'h44, value);
		runAccess(opLw, 32'h20, '0, value);
		checkValue("oRespData", value, 32'h4433_2211);
		runAccess(opSh, 32'h22, 32'h1234_BEEF, value);
		runAccess(opLw, 32'h20, '0, value);
		checkValue("oRespData", value, 32'hBEEF_2211);
	endtask

	task automatic testExtension();
		wordT value;
		runAccess(opSw, 32'h30, 32'h9A80_F07F, value);
		runAccess(opLb, 32'h31, '0, value);
		checkValue("oRespData", value, 32'hFFFF_FFF0);
		runAccess(opLbu, 32'h31, '0, value);
		checkValue("oRespData", value, 32'h0000_00F0);
		runAccess(opLh, 32'h32, '0, value);
		checkValue("oRespData", value, 32'hFFFF_9A80);
		runAccess(opLhu, 32'h32, '0, value);
		checkValue("oRespData", value, 32'h0000_9A80);
	endtask

	task automatic testMisaligned();
		wordT value;
		runAccess(opSw, 32'h40, 32'h0123_4567, value);
		runAccess(opSw, 32'h44, 32'h89AB_CDEF, value);
		runAccess(opLh, 32'h41, '0, value);
		runAccess(opSh, 32'h43, 32'hFFFF, value);
		runAccess(opLhu, 32'h45, '0, value);
		runAccess(opSw, 32'h42, 32'hFFFF_FFFF, value);
		runAccess(opSw, 32'h45, 32'hFFFF_FFFF, value);
		runAccess(opLw, 32'h47, '0, value);
		runAccess(opLw, 32'h40, '0, value);
		checkValue("oRespData", value, 32'h0123_4567);
		runAccess(opLw, 32'h44, '0, value);
		checkValue("oRespData", value, 32'h89AB_CDEF);
	endtask

	task automatic testRandom();
		accessOpT ops [8] = '{opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
		accessOpT op;
		logic [31:0] addr;
		wordT data;
		wordT value;
		for (int n = 0; n < 200; n++)
		begin
			op = ops[randomBits(3)];
			addr = randomBits(10); // stays inside the model
			data = writesMemory(op) ? randomBits(32) : '0;
			runAccess(op, addr, data, value);
		end
	endtask

	initial
	begin
		iCLK = 1'b0;
		iRST = 1'b1;
		reqValid = 1'b0;
		reqOp = opLw;
		reqAddr = '0;
		reqData = '0;
		errorCount = 0;
		checkCount = 0;
		lfsrState = 32'd67427;
		for (int i = 0; i < MEM_BYTES; i++)
		begin
			refMem[i] = 8'h00; // model memory starts cleared too
		end
		repeat (8) @(posedge iCLK);
		iRST <= 1'b0;
		@(negedge iCLK);
		testResetAndWord();
		testByteLanes();
		testExtension();
		testMisaligned();
		testRandom();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
